/* build.f */
common/dcache_pkg.sv
common/dcache_lookup_if.sv
dcache/dcache_controller.sv
dcache/dcache_mem.sv
dcache/dcache_result.sv
hw/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

/* common/dcache_lookup_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dcache_lookup_if
	import dcache_pkg::*;
#(
	parameter int INDEX_BITS = 3,
	parameter int TAG_BITS   = 13
);
	// request side, one-cycle strobes
	logic [INDEX_BITS-1:0]  index;
	logic [TAG_BITS-1:0]    tag;
	logic                   read_enable;
	logic                   write_enable;
	block_t                 write_data;
	mem_tag_t               mem_response;
	mem_tag_t               fill_tag;
	block_t                 fill_data;

	// answers, same cycle as the strobe
	logic                   hit;
	logic                   miss;
	logic                   victim_dirty;
	logic [TAG_BITS-1:0]    victim_tag;
	block_t                 victim_data;
	logic                   fill_done;

	modport ctrl
	(
		output index, tag, read_enable, write_enable, write_data,
		output mem_response, fill_tag, fill_data,
		input  hit, miss, victim_dirty, victim_tag, victim_data, fill_done
	);

	modport mem
	(
		input  index, tag, read_enable, write_enable, write_data,
		input  mem_response, fill_tag, fill_data,
		output hit, miss, victim_dirty, victim_tag, victim_data, fill_done
	);

endinterface

`default_nettype wire

/* common/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// block address, no byte offset
	localparam int ADDR_BITS  = 16;
	localparam int BLOCK_BITS = 64;
	localparam int TAG_ID_BITS = 4;

	typedef logic [ADDR_BITS-1:0]   addr_t;
	typedef logic [BLOCK_BITS-1:0]  block_t;

	// zero means no transaction or not accepted
	typedef logic [TAG_ID_BITS-1:0] mem_tag_t;

	// shared by the processor and memory ports
	typedef enum logic [1:0]
	{
		CMD_NONE  = 2'd0,
		CMD_LOAD  = 2'd1,
		CMD_STORE = 2'd2
	} proc_cmd_t;

endpackage

`default_nettype wire

/* dcache/dcache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_controller
	import dcache_pkg::*;
#(
	parameter int NUM_SETS = 8
)
(
	input  logic                clock,
	input  logic                reset,
	input  proc_cmd_t           proc_command,
	input  addr_t               proc_addr,
	input  block_t              proc_data,
	output logic                proc_busy,
	output proc_cmd_t           mem_command,
	output addr_t               mem_addr,
	output block_t              mem_store_data,
	input  mem_tag_t            mem_response,
	input  mem_tag_t            mem_tag,
	input  block_t              mem_load_data,
	dcache_lookup_if.ctrl       lookup,
	output logic                complete,
	output logic                complete_is_load,
	output logic                complete_hit
);
	localparam int INDEX_BITS = $clog2(NUM_SETS);

	typedef enum logic [2:0]
	{
		IDLE,
		LOOKUP,
		WRITEBACK,
		FETCH,
		WAIT_FILL
	} state_t;

	state_t     state;
	state_t     state_next;
	proc_cmd_t  req_cmd;
	addr_t      req_addr;
	block_t     req_data;
	addr_t      wb_addr;
	block_t     wb_data;
	logic       accepted;
	logic       strobe;

	assign accepted  = (mem_response != '0);
	assign proc_busy = (state != IDLE);

	assign lookup.index      = req_addr[INDEX_BITS-1:0];
	assign lookup.tag        = req_addr[ADDR_BITS-1:INDEX_BITS];
	assign lookup.write_data = req_data;
	// only a fetch response is worth recording on a line
	assign lookup.mem_response = (state == FETCH) ? mem_response : '0;
	assign lookup.fill_tag     = mem_tag;
	assign lookup.fill_data    = mem_load_data;

	always_comb
	begin
		strobe = (state == LOOKUP) || ((state == FETCH) && accepted);
		lookup.read_enable  = strobe && (req_cmd == CMD_LOAD);
		lookup.write_enable = strobe && (req_cmd == CMD_STORE);
	end

	// held until memory answers with a nonzero response
	always_comb
	begin
		mem_command    = CMD_NONE;
		mem_addr       = req_addr;
		mem_store_data = wb_data;
		case (state)
			WRITEBACK:
			begin
				mem_command = CMD_STORE;
				mem_addr    = wb_addr;
			end
			FETCH:
				mem_command = CMD_LOAD;
			default:
				mem_command = CMD_NONE;
		endcase
	end

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (proc_command != CMD_NONE)
					state_next = LOOKUP;
			LOOKUP:
				if (lookup.hit)
					state_next = IDLE;
				else if (lookup.miss)
					state_next = lookup.victim_dirty ? WRITEBACK : FETCH;
			WRITEBACK:
				if (accepted)
					state_next = FETCH;
			FETCH:
				if (accepted)
					state_next = WAIT_FILL;
			WAIT_FILL:
				if (lookup.fill_done)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clock)
	begin
		if ((state == IDLE) && (proc_command != CMD_NONE))
		begin
			req_cmd  <= proc_command;
			req_addr <= proc_addr;
			req_data <= proc_data;
		end
		// victim info is only valid during the lookup strobe
		if (state == LOOKUP)
		begin
			wb_addr <= {lookup.victim_tag, lookup.index};
			wb_data <= lookup.victim_data;
		end
	end

	assign complete = ((state == LOOKUP) && lookup.hit) ||
		((state == WAIT_FILL) && lookup.fill_done);
	assign complete_hit     = (state == LOOKUP);
	assign complete_is_load = (req_cmd == CMD_LOAD);

endmodule

`default_nettype wire

/* dcache/dcache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_mem
	import dcache_pkg::*;
#(
	parameter int NUM_SETS = 8
)
(
	input  logic            clock,
	input  logic            reset,
	dcache_lookup_if.mem    lookup,
	output block_t          data_out
);
	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS;

	typedef logic [TAG_BITS-1:0] tag_t;

	tag_t                       tag_mem   [NUM_SETS][2];
	block_t                     data_mem  [NUM_SETS][2];
	mem_tag_t                   resp_tag  [NUM_SETS][2];
	logic                       pend_load [NUM_SETS][2];
	logic [NUM_SETS-1:0][1:0]   valid;
	logic [NUM_SETS-1:0][1:0]   dirty;
	// next victim way per set
	logic [NUM_SETS-1:0]        lru;

	logic                       access;
	logic [1:0]                 way_hit;
	logic                       hit_way;
	logic                       victim;
	logic                       fill_found;
	logic [INDEX_BITS-1:0]      fill_set;
	logic                       fill_way;

	always_comb
	begin
		access = lookup.read_enable || lookup.write_enable;
		for (int w = 0; w < 2; w++)
			way_hit[w] = valid[lookup.index][w] && (tag_mem[lookup.index][w] == lookup.tag);
		hit_way = way_hit[1];
		victim  = lru[lookup.index];

		lookup.hit          = access && (way_hit != 2'b00);
		lookup.miss         = access && (way_hit == 2'b00);
		lookup.victim_dirty = lookup.miss && dirty[lookup.index][victim];
		lookup.victim_tag   = tag_mem[lookup.index][victim];
		lookup.victim_data  = data_mem[lookup.index][victim];
	end

	// match a returning tag against the pending lines
	always_comb
	begin
		fill_found = 1'b0;
		fill_set   = '0;
		fill_way   = 1'b0;
		for (int s = 0; s < NUM_SETS; s++)
		begin
			for (int w = 0; w < 2; w++)
			begin
				if (!fill_found && (lookup.fill_tag != '0) &&
					(resp_tag[s][w] == lookup.fill_tag))
				begin
					fill_found = 1'b1;
					fill_set   = INDEX_BITS'(s);
					fill_way   = w[0];
				end
			end
		end
		lookup.fill_done = fill_found;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid    <= '0;
			dirty    <= '0;
			lru      <= '0;
			resp_tag <= '{default: '0};
		end
		else
		begin
			if (lookup.hit)
			begin
				lru[lookup.index] <= ~hit_way;
				if (lookup.write_enable)
					dirty[lookup.index][hit_way] <= 1'b1;
			end
			else if (lookup.miss)
			begin
				// dirty victim goes out first, the copy in the controller is the one written
				if (dirty[lookup.index][victim])
					dirty[lookup.index][victim] <= 1'b0;
				else
				begin
					valid[lookup.index][victim]    <= 1'b0;
					resp_tag[lookup.index][victim] <= lookup.mem_response;
				end
			end
			if (fill_found)
			begin
				valid[fill_set][fill_way]    <= 1'b1;
				dirty[fill_set][fill_way]    <= ~pend_load[fill_set][fill_way];
				resp_tag[fill_set][fill_way] <= '0;
				lru[fill_set]                <= ~fill_way;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (lookup.hit && lookup.write_enable)
			data_mem[lookup.index][hit_way] <= lookup.write_data;
		if (lookup.miss && !dirty[lookup.index][victim])
		begin
			tag_mem[lookup.index][victim]   <= lookup.tag;
			pend_load[lookup.index][victim] <= lookup.read_enable;
		end
		if (fill_found)
		begin
			// a store miss allocates with its own block
			if (pend_load[fill_set][fill_way])
				data_mem[fill_set][fill_way] <= lookup.fill_data;
			else
				data_mem[fill_set][fill_way] <= lookup.write_data;
		end

		if (lookup.hit && lookup.read_enable)
			data_out <= data_mem[lookup.index][hit_way];
		else if (fill_found && pend_load[fill_set][fill_way])
			data_out <= lookup.fill_data;
	end

endmodule

`default_nettype wire

/* dcache/dcache_result.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_result
	import dcache_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    complete,
	input  logic    complete_hit,
	input  logic    complete_is_load,
	input  block_t  data_out,
	output logic    proc_done,
	output logic    proc_hit,
	output block_t  proc_rdata
);
	logic       load_done;
	block_t     rdata_q;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			proc_done <= 1'b0;
			proc_hit  <= 1'b0;
			load_done <= 1'b0;
			rdata_q   <= '0;
		end
		else
		begin
			proc_done <= complete;
			proc_hit  <= complete && complete_hit;
			load_done <= complete && complete_is_load;
			rdata_q   <= proc_rdata;
		end
	end

	// data_out lands on the same edge as the done pulse
	assign proc_rdata = load_done ? data_out : rdata_q;

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top
	import dcache_pkg::*;
#(
	parameter int NUM_SETS = 8
)
(
	input  logic        clock,
	input  logic        reset,
	input  proc_cmd_t   proc_command,
	input  addr_t       proc_addr,
	input  block_t      proc_data,
	output logic        proc_busy,
	output logic        proc_done,
	output logic        proc_hit,
	output block_t      proc_rdata,
	output proc_cmd_t   mem_command,
	output addr_t       mem_addr,
	output block_t      mem_store_data,
	input  mem_tag_t    mem_response,
	input  mem_tag_t    mem_tag,
	input  block_t      mem_load_data
);
	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS;

	logic       complete;
	logic       complete_is_load;
	logic       complete_hit;
	block_t     data_out;

	dcache_lookup_if #(.INDEX_BITS(INDEX_BITS), .TAG_BITS(TAG_BITS)) lookup ();

	dcache_controller #(.NUM_SETS(NUM_SETS)) i_dcache_controller
	(
		.clock            (clock),
		.reset            (reset),
		.proc_command     (proc_command),
		.proc_addr        (proc_addr),
		.proc_data        (proc_data),
		.proc_busy        (proc_busy),
		.mem_command      (mem_command),
		.mem_addr         (mem_addr),
		.mem_store_data   (mem_store_data),
		.mem_response     (mem_response),
		.mem_tag          (mem_tag),
		.mem_load_data    (mem_load_data),
		.lookup           (lookup.ctrl),
		.complete         (complete),
		.complete_is_load (complete_is_load),
		.complete_hit     (complete_hit)
	);

	dcache_mem #(.NUM_SETS(NUM_SETS)) i_dcache_mem
	(
		.clock    (clock),
		.reset    (reset),
		.lookup   (lookup.mem),
		.data_out (data_out)
	);

	dcache_result i_dcache_result
	(
		.clock            (clock),
		.reset            (reset),
		.complete         (complete),
		.complete_hit     (complete_hit),
		.complete_is_load (complete_is_load),
		.data_out         (data_out),
		.proc_done        (proc_done),
		.proc_hit         (proc_hit),
		.proc_rdata       (proc_rdata)
	);

endmodule

`default_nettype wire

/* tb/dcache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
	import dcache_pkg::*;
#(
	parameter logic [31:0] SEED = 32'hfb52c9ac
)
(
	input  logic        clock,
	input  logic        reset,
	input  proc_cmd_t   mem_command,
	input  addr_t       mem_addr,
	input  block_t      mem_store_data,
	output mem_tag_t    mem_response,
	output mem_tag_t    mem_tag,
	output block_t      mem_load_data
);
	block_t         mem [0:65535];
	logic [31:0]    rand_state;
	logic           refuse;
	mem_tag_t       next_tag;
	logic           pend_valid;
	int             pend_wait;
	mem_tag_t       pend_tag;
	block_t         pend_data;

	function automatic logic [31:0] next_random(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic block_t initial_contents(input addr_t a);
		return {a, ~a, a * 16'd3 + 16'h1d4b, a ^ 16'ha5c3};
	endfunction

	initial
	begin
		for (int a = 0; a < 65536; a++)
			mem[a] = initial_contents(addr_t'(a));
		rand_state    = SEED;
		refuse        = 1'b0;
		next_tag      = 4'd1;
		pend_valid    = 1'b0;
		pend_wait     = 0;
		pend_tag      = '0;
		pend_data     = '0;
		mem_tag       = '0;
		mem_load_data = '0;
	end

	// zero response means the command was refused this cycle
	assign mem_response = ((mem_command != CMD_NONE) && !refuse) ? next_tag : '0;

	always @(posedge clock)
	begin
		rand_state = next_random(rand_state);
		if (reset)
		begin
			refuse     <= 1'b0;
			next_tag   <= 4'd1;
			pend_valid <= 1'b0;
			mem_tag    <= '0;
		end
		else
		begin
			mem_tag <= '0;
			if (pend_valid)
			begin
				if (pend_wait == 0)
				begin
					mem_tag       <= pend_tag;
					mem_load_data <= pend_data;
					pend_valid    <= 1'b0;
				end
				else
					pend_wait <= pend_wait - 1;
			end
			if (mem_response != '0)
			begin
				if (mem_command == CMD_STORE)
					mem[mem_addr] <= mem_store_data;
				else
				begin
					pend_valid <= 1'b1;
					pend_tag   <= mem_response;
					pend_data  <= mem[mem_addr];
					// load data comes back 1 to 6 cycles later
					pend_wait  <= rand_state[26:24] % 6;
				end
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			// about one command in four is refused
			refuse <= (rand_state[17:16] == 2'b00);
		end
	end

endmodule

`default_nettype wire

/* tb/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
	import dcache_pkg::*;
();
	localparam int NUM_SETS    = 8;
	localparam int NUM_ENTRIES = 16;
	localparam int NUM_RUNS    = 2 * NUM_ENTRIES;
	localparam int CYCLE_LIMIT = NUM_RUNS * 40;

	logic       clock;
	logic       reset;
	proc_cmd_t  proc_command;
	addr_t      proc_addr;
	block_t     proc_data;
	logic       proc_busy;
	logic       proc_done;
	logic       proc_hit;
	block_t     proc_rdata;
	proc_cmd_t  mem_command;
	addr_t      mem_addr;
	block_t     mem_store_data;
	mem_tag_t   mem_response;
	mem_tag_t   mem_tag;
	block_t     mem_load_data;

	// stimulus table and expected results for both passes
	proc_cmd_t  cmd_tab  [NUM_ENTRIES];
	addr_t      addr_tab [NUM_ENTRIES];
	block_t     data_tab [NUM_ENTRIES];
	logic       exp_hit   [NUM_RUNS];
	logic       exp_check [NUM_RUNS];
	block_t     exp_data  [NUM_RUNS];

	// shadow cache and memory
	addr_t      sh_addr  [NUM_SETS][2];
	block_t     sh_data  [NUM_SETS][2];
	logic       sh_valid [NUM_SETS][2];
	logic       sh_dirty [NUM_SETS][2];
	logic       sh_lru   [NUM_SETS];
	block_t     sh_mem   [0:65535];
	addr_t      wb_addr_q [$];
	block_t     wb_data_q [$];

	proc_cmd_t  last_cmd;
	addr_t      last_addr;
	mem_tag_t   last_resp;
	int         cycles;
	logic [31:0] rand_state;

	dcache_top #(.NUM_SETS(NUM_SETS)) i_dcache_top
	(
		.clock          (clock),
		.reset          (reset),
		.proc_command   (proc_command),
		.proc_addr      (proc_addr),
		.proc_data      (proc_data),
		.proc_busy      (proc_busy),
		.proc_done      (proc_done),
		.proc_hit       (proc_hit),
		.proc_rdata     (proc_rdata),
		.mem_command    (mem_command),
		.mem_addr       (mem_addr),
		.mem_store_data (mem_store_data),
		.mem_response   (mem_response),
		.mem_tag        (mem_tag),
		.mem_load_data  (mem_load_data)
	);

	dcache_mem_model #(.SEED(32'hfb52c9ac)) i_mem_model
	(
		.clock          (clock),
		.reset          (reset),
		.mem_command    (mem_command),
		.mem_addr       (mem_addr),
		.mem_store_data (mem_store_data),
		.mem_response   (mem_response),
		.mem_tag        (mem_tag),
		.mem_load_data  (mem_load_data)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic set_entry(input int i, input proc_cmd_t c, input addr_t a, input block_t d);
		cmd_tab[i]  = c;
		addr_tab[i] = a;
		data_tab[i] = d;
	endtask

	task automatic fill_table();
		// set 3 gets a miss, a hit, a store hit and a dirty eviction
		set_entry(0,  CMD_LOAD,  16'h0013, '0);
		set_entry(1,  CMD_LOAD,  16'h0013, '0);
		set_entry(2,  CMD_STORE, 16'h0013, 64'h0123_4567_89ab_cdef);
		set_entry(3,  CMD_LOAD,  16'h0013, '0);
		set_entry(4,  CMD_LOAD,  16'h0113, '0);
		set_entry(5,  CMD_LOAD,  16'h0213, '0);
		set_entry(6,  CMD_LOAD,  16'h0013, '0);
		// store miss in set 5 allocates a dirty line
		set_entry(7,  CMD_STORE, 16'h0045, 64'hfeed_face_cafe_beef);
		set_entry(8,  CMD_LOAD,  16'h0045, '0);
		set_entry(9,  CMD_LOAD,  16'h1005, '0);
		set_entry(10, CMD_LOAD,  16'h2005, '0);
		set_entry(11, CMD_LOAD,  16'h0045, '0);
		set_entry(12, CMD_STORE, 16'h0307, 64'h5a5a_0f0f_a5a5_f0f0);
		set_entry(13, CMD_LOAD,  16'hfff8, '0);
		set_entry(14, CMD_LOAD,  16'h0307, '0);
		set_entry(15, CMD_STORE, 16'h0013, 64'h1357_9bdf_2468_ace0);
	endtask

	// one access of the two-way shadow cache with its lru bit
	task automatic model_access(input int k);
		int e;
		int s;
		int w;
		logic found;
		e = k % NUM_ENTRIES;
		s = addr_tab[e] % NUM_SETS;
		found = 1'b0;
		w = 0;
		for (int i = 0; i < 2; i++)
		begin
			if (sh_valid[s][i] && (sh_addr[s][i] == addr_tab[e]))
			begin
				found = 1'b1;
				w = i;
			end
		end
		if (!found)
		begin
			w = sh_lru[s];
			if (sh_valid[s][w] && sh_dirty[s][w])
			begin
				wb_addr_q.push_back(sh_addr[s][w]);
				wb_data_q.push_back(sh_data[s][w]);
				sh_mem[sh_addr[s][w]] = sh_data[s][w];
			end
			sh_valid[s][w] = 1'b1;
			sh_dirty[s][w] = 1'b0;
			sh_addr[s][w]  = addr_tab[e];
			sh_data[s][w]  = sh_mem[addr_tab[e]];
		end
		if (cmd_tab[e] == CMD_STORE)
		begin
			sh_data[s][w]  = data_tab[e];
			sh_dirty[s][w] = 1'b1;
		end
		sh_lru[s]    = (w == 0);
		exp_hit[k]   = found;
		exp_check[k] = (cmd_tab[e] == CMD_LOAD);
		exp_data[k]  = sh_data[s][w];
	endtask

	task automatic fill_expected();
		for (int a = 0; a < 65536; a++)
			sh_mem[a] = i_mem_model.mem[a];
		for (int s = 0; s < NUM_SETS; s++)
		begin
			sh_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				sh_valid[s][w] = 1'b0;
				sh_dirty[s][w] = 1'b0;
			end
		end
		for (int k = 0; k < NUM_RUNS; k++)
			model_access(k);
	endtask

	task automatic run_entry(input int k);
		int e;
		int waited;
		e = k % NUM_ENTRIES;
		assert (!proc_busy)
		else report_failure($sformatf("[FAIL] proc_busy: got %h expected %h before step %0d",
			proc_busy, 1'b0, k));
		proc_command = cmd_tab[e];
		proc_addr    = addr_tab[e];
		proc_data    = data_tab[e];
		@(negedge clock);
		proc_command = CMD_NONE;
		waited = 1;
		while (!proc_done)
		begin
			assert (proc_busy)
			else report_failure($sformatf("[FAIL] proc_busy: got %h expected %h at step %0d",
				proc_busy, 1'b1, k));
			if (exp_hit[k])
			begin
				assert (mem_command == CMD_NONE)
				else report_failure($sformatf("[FAIL] mem_command: got %h expected %h",
					mem_command, CMD_NONE));
			end
			@(negedge clock);
			waited++;
		end
		assert (proc_hit == exp_hit[k])
		else report_failure($sformatf("[FAIL] proc_hit: got %h expected %h at step %0d",
			proc_hit, exp_hit[k], k));
		if (exp_hit[k])
		begin
			assert (waited == 2)
			else report_failure($sformatf("hit at step %0d finished after %0d cycles, not 2",
				k, waited));
		end
		if (exp_check[k])
		begin
			assert (proc_rdata == exp_data[k])
			else report_failure($sformatf("[FAIL] proc_rdata: got %h expected %h at step %0d",
				proc_rdata, exp_data[k], k));
		end
	endtask

	// write-backs and held commands under back-pressure
	always @(negedge clock)
	begin
		if (!reset)
		begin
			if ((mem_command == CMD_STORE) && (mem_response != '0))
			begin
				assert (wb_addr_q.size() > 0)
				else report_failure("memory got a store that no eviction explains");
				assert (mem_addr == wb_addr_q[0])
				else report_failure($sformatf("[FAIL] mem_addr: got %h expected %h",
					mem_addr, wb_addr_q[0]));
				assert (mem_store_data == wb_data_q[0])
				else report_failure($sformatf("[FAIL] mem_store_data: got %h expected %h",
					mem_store_data, wb_data_q[0]));
				wb_addr_q.delete(0);
				wb_data_q.delete(0);
			end
			if ((last_cmd != CMD_NONE) && (last_resp == '0))
			begin
				assert (mem_command == last_cmd)
				else report_failure($sformatf("[FAIL] mem_command: got %h expected %h",
					mem_command, last_cmd));
				assert (mem_addr == last_addr)
				else report_failure($sformatf("[FAIL] mem_addr: got %h expected %h",
					mem_addr, last_addr));
			end
			last_cmd  = mem_command;
			last_addr = mem_addr;
			last_resp = mem_response;
		end
	end

	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT)
			report_failure("the run went past its cycle limit");
	end

	initial
	begin
		int gap;
		reset        = 1'b1;
		proc_command = CMD_NONE;
		proc_addr    = '0;
		proc_data    = '0;
		last_cmd     = CMD_NONE;
		last_addr    = '0;
		last_resp    = '0;
		cycles       = 0;
		rand_state   = 32'hfb52c9ac;
		fill_table();
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		fill_expected();

		assert (!proc_busy)
		else report_failure($sformatf("[FAIL] proc_busy: got %h expected %h",
			proc_busy, 1'b0));
		assert (!proc_done)
		else report_failure($sformatf("[FAIL] proc_done: got %h expected %h",
			proc_done, 1'b0));
		assert (!proc_hit)
		else report_failure($sformatf("[FAIL] proc_hit: got %h expected %h",
			proc_hit, 1'b0));
		assert (mem_command == CMD_NONE)
		else report_failure($sformatf("[FAIL] mem_command: got %h expected %h",
			mem_command, CMD_NONE));
		assert (proc_rdata == '0)
		else report_failure($sformatf("[FAIL] proc_rdata: got %h expected %h",
			proc_rdata, 64'h0));

		for (int k = 0; k < NUM_ENTRIES; k++)
			run_entry(k);
		// second pass with idle gaps between commands
		for (int k = NUM_ENTRIES; k < NUM_RUNS; k++)
		begin
			rand_state = next_random(rand_state);
			gap = rand_state[29:28];
			repeat (gap) @(negedge clock);
			run_entry(k);
		end

		assert (wb_addr_q.size() == 0)
		else report_failure("an expected write-back never reached memory");
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
